// ==== include/wb_cfg.svh ====
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// datapath and address width
`define WB_XLEN 32

// architectural integer registers
`define WB_NREG 32

// register address width, log2 of WB_NREG
`define WB_RAW 5

// one quotient bit per iteration
`define WB_DIV_STEPS `WB_XLEN

`endif

// ==== hw/wb_pkg.sv ====
package wb_pkg;

    // bit positions inside the 5-bit class field
    localparam int UOP_ALU  = 4;
    localparam int UOP_LINK = 3;
    localparam int UOP_DIV  = 2;
    localparam int UOP_MEM  = 1;
    localparam int UOP_ERTN = 0;

    // low three bits mean different things for divides and memory ops
    typedef union packed {
        struct packed {
            logic [4:0] cls;
            logic [1:0] spare;
            logic       rem;
        } div_view;
        struct packed {
            logic [4:0] cls;
            logic       store;
            logic [1:0] size;
        } mem_view;
    } uop_u;

    typedef enum logic [5:0] {
        INT  = 6'h00,
        PIL  = 6'h01,
        PIS  = 6'h02,
        PIF  = 6'h03,
        PME  = 6'h04,
        PPI  = 6'h07,
        ADEF = 6'h08,
        ALE  = 6'h09,
        SYS  = 6'h0b,
        BRK  = 6'h0c,
        INE  = 6'h0d,
        TLBR = 6'h3f
    } ecode_e;

    // what the commit stage redirects for
    typedef enum logic [1:0] {
        REDIR_NONE,
        REDIR_EXC,
        REDIR_TLBR,
        REDIR_ERTN
    } redir_e;

endpackage

// ==== hw/int_divider.sv ====
`timescale 1ns/10ps
`include "wb_cfg.svh"

module int_divider (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                start,
    input  logic [`WB_XLEN-1:0] dividend,
    input  logic [`WB_XLEN-1:0] divisor,
    output logic                busy,
    output logic                ready,
    output logic [`WB_XLEN-1:0] quotient,
    output logic [`WB_XLEN-1:0] remainder
);

    localparam int CW = $clog2(`WB_DIV_STEPS + 1);

    logic [CW-1:0]       step;
    logic [`WB_XLEN-1:0] dsor;
    logic [`WB_XLEN:0]   trial;
    logic [`WB_XLEN:0]   diff;
    logic                fits;

    // partial remainder with the next dividend bit shifted in
    assign trial = {remainder, quotient[`WB_XLEN-1]};
    assign diff  = trial - {1'b0, dsor};
    assign fits  = trial >= {1'b0, dsor};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            busy  <= 1'b0;
            ready <= 1'b0;
            step  <= '0;
        end else begin
            ready <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == CW'(`WB_DIV_STEPS - 1)) begin
                    busy  <= 1'b0;
                    ready <= 1'b1;
                end
            end
        end
    end

    // quotient register doubles as the dividend shifter
    // divisor zero always fits: all-ones quotient, dividend left as remainder
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            quotient  <= dividend;
            remainder <= '0;
            dsor      <= divisor;
        end else if (busy) begin
            quotient  <= {quotient[`WB_XLEN-2:0], fits};
            remainder <= fits ? diff[`WB_XLEN-1:0] : trial[`WB_XLEN-1:0];
        end
    end

    // a start during iteration is dropped, upstream must wait for ready
    assert property (@(posedge clk) disable iff (!aresetn) start |-> !busy)
        else $error("int_divider: start while busy");

endmodule

// ==== hw/wb_select.sv ====
`timescale 1ns/10ps
`include "wb_cfg.svh"

module wb_select (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                flush,
    input  logic                lane0_valid,
    input  logic [`WB_RAW-1:0]  lane0_rd,
    input  wb_pkg::uop_u        lane0_uop,
    input  logic [`WB_XLEN-1:0] lane0_result,
    input  logic                lane1_valid,
    input  logic [`WB_RAW-1:0]  lane1_rd,
    input  wb_pkg::uop_u        lane1_uop,
    input  logic [`WB_XLEN-1:0] lane1_result,
    input  logic                csr_rd_valid,
    input  logic [`WB_XLEN-1:0] csr_rdata,
    input  logic                div_busy,
    input  logic                div_ready,
    input  logic [`WB_XLEN-1:0] quotient,
    input  logic [`WB_XLEN-1:0] remainder,
    input  logic                load_issue,
    input  logic [`WB_RAW-1:0]  load_rd,
    input  logic [`WB_XLEN-1:0] load_data,
    input  logic                load_ready,
    output logic                we0,
    output logic [`WB_RAW-1:0]  waddr0,
    output logic [`WB_XLEN-1:0] wdata0,
    output logic                we1,
    output logic [`WB_RAW-1:0]  waddr1,
    output logic [`WB_XLEN-1:0] wdata1,
    output logic                we2,
    output logic [`WB_RAW-1:0]  waddr2,
    output logic [`WB_XLEN-1:0] wdata2,
    output logic                allowin
);

    logic                sel0_exec;
    logic                sel0_csr;
    logic                sel0_div;
    logic                sel1_exec;
    logic                sel1_div;
    logic [`WB_XLEN-1:0] data0;
    logic [`WB_XLEN-1:0] data1;
    logic                load_take;
    logic                load_pend;
    logic [`WB_RAW-1:0]  pend_rd;

    // alu and link results come straight from execute
    function automatic logic exec_hit(input logic valid, input wb_pkg::uop_u uop);
        return valid && (uop.div_view.cls[wb_pkg::UOP_ALU] ||
                         uop.div_view.cls[wb_pkg::UOP_LINK]);
    endfunction

    function automatic logic [`WB_XLEN-1:0] exec_data(input wb_pkg::uop_u uop,
                                                      input logic [`WB_XLEN-1:0] result);
        // link writes the return address
        return uop.div_view.cls[wb_pkg::UOP_LINK] ? result + 4 : result;
    endfunction

    function automatic logic [`WB_XLEN-1:0] div_data(input wb_pkg::uop_u uop,
                                                     input logic [`WB_XLEN-1:0] quo,
                                                     input logic [`WB_XLEN-1:0] rem);
        return uop.div_view.rem ? rem : quo;
    endfunction

    // the divide uop stays on its lane from start until ready
    always_comb begin
        sel0_exec = exec_hit(lane0_valid, lane0_uop);
        sel0_csr  = !sel0_exec && csr_rd_valid;
        sel0_div  = !sel0_exec && !csr_rd_valid && div_ready &&
                    lane0_uop.div_view.cls[wb_pkg::UOP_DIV];
        sel1_exec = exec_hit(lane1_valid, lane1_uop);
        sel1_div  = !sel1_exec && div_ready && lane1_uop.div_view.cls[wb_pkg::UOP_DIV];

        if (sel0_exec) begin
            data0 = exec_data(lane0_uop, lane0_result);
        end else if (sel0_csr) begin
            data0 = csr_rdata;
        end else begin
            data0 = div_data(lane0_uop, quotient, remainder);
        end

        if (sel1_exec) begin
            data1 = exec_data(lane1_uop, lane1_result);
        end else begin
            data1 = div_data(lane1_uop, quotient, remainder);
        end
    end

    // only a load on lane 0 opens the load lane, stores never write
    assign load_take = load_issue && lane0_uop.mem_view.cls[wb_pkg::UOP_MEM] &&
                       !lane0_uop.mem_view.store;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            we0       <= 1'b0;
            we1       <= 1'b0;
            we2       <= 1'b0;
            load_pend <= 1'b0;
        end else begin
            // results behind an exception are dropped
            we0 <= !flush && (sel0_exec || sel0_csr || sel0_div);
            we1 <= !flush && (sel1_exec || sel1_div);
            // load_ready is expected at least one cycle after issue
            we2 <= load_ready && load_pend;
            if (load_take) begin
                load_pend <= 1'b1;
            end else if (load_ready) begin
                load_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        waddr0 <= lane0_rd;
        wdata0 <= data0;
        waddr1 <= lane1_rd;
        wdata1 <= data1;
        waddr2 <= pend_rd;
        wdata2 <= load_data;
        if (load_take) begin
            pend_rd <= load_rd;
        end
    end

    assign allowin = !div_busy && !(load_pend && !load_ready);

    // a new load may only follow the return of the previous one
    assert property (@(posedge clk) disable iff (!aresetn)
        load_take |-> !load_pend || load_ready)
        else $error("wb_select: second load issued while one is outstanding");

    // issue never pairs two writers of one register
    assert property (@(posedge clk) disable iff (!aresetn)
        we0 && we1 && waddr0 != '0 |-> waddr0 != waddr1)
        else $error("wb_select: both lanes write register %0d", waddr0);

endmodule

// ==== hw/exc_commit.sv ====
`timescale 1ns/10ps
`include "wb_cfg.svh"

module exc_commit (
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 exc_valid,
    input  logic [5:0]           exc_code,
    input  logic [`WB_XLEN-1:0]  exc_badv,
    input  logic [`WB_XLEN-1:0]  exc_era,
    input  logic                 intr,
    input  logic                 lane0_valid,
    input  wb_pkg::uop_u         lane0_uop,
    input  logic [`WB_XLEN-1:0]  eentry,
    input  logic [`WB_XLEN-1:0]  tlbrentry,
    input  logic [`WB_XLEN-1:0]  csr_era,
    output logic                 flush,
    output logic                 redirect_valid,
    output logic [`WB_XLEN-1:0]  redirect_pc,
    output logic [5:0]           ecode_out,
    output logic                 badv_we,
    output logic [`WB_XLEN-1:0]  badv,
    output logic                 era_we,
    output logic [`WB_XLEN-1:0]  era,
    output logic                 vppn_we,
    output logic [`WB_XLEN-14:0] vppn
);

    wb_pkg::ecode_e code;
    wb_pkg::redir_e cause;
    logic           take;
    logic           ertn;
    logic           set_badv;
    logic           set_vppn;

    // intr is a level, the CSR side masks it once taken
    assign take = exc_valid || intr;
    assign ertn = lane0_valid && lane0_uop.div_view.cls[wb_pkg::UOP_ERTN];

    always_comb begin
        // synchronous exception outranks the interrupt
        if (exc_valid) begin
            code = wb_pkg::ecode_e'(exc_code);
        end else begin
            code = wb_pkg::INT;
        end
        set_badv = 1'b0;
        set_vppn = 1'b0;
        case (code)
            wb_pkg::PIL, wb_pkg::PIS, wb_pkg::PIF, wb_pkg::PME, wb_pkg::PPI,
            wb_pkg::TLBR: begin
                set_badv = 1'b1;
                set_vppn = 1'b1;
            end
            // address errors carry no page number
            wb_pkg::ADEF, wb_pkg::ALE: begin
                set_badv = 1'b1;
            end
            default: begin
                set_badv = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            cause     <= wb_pkg::REDIR_NONE;
            ecode_out <= '0;
            badv_we   <= 1'b0;
            era_we    <= 1'b0;
            vppn_we   <= 1'b0;
        end else begin
            badv_we <= exc_valid && set_badv;
            vppn_we <= exc_valid && set_vppn;
            era_we  <= take;
            if (take) begin
                ecode_out <= code;
                cause     <= (code == wb_pkg::TLBR) ? wb_pkg::REDIR_TLBR : wb_pkg::REDIR_EXC;
            end else if (ertn) begin
                cause <= wb_pkg::REDIR_ERTN;
            end else begin
                cause <= wb_pkg::REDIR_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            badv <= exc_badv;
            era  <= exc_era;
        end
    end

    assign vppn = badv[`WB_XLEN-1:13];

    assign flush          = cause != wb_pkg::REDIR_NONE;
    assign redirect_valid = flush;

    always_comb begin
        case (cause)
            wb_pkg::REDIR_TLBR: redirect_pc = tlbrentry;
            wb_pkg::REDIR_ERTN: redirect_pc = csr_era;
            default:            redirect_pc = eentry;
        endcase
    end

endmodule

// ==== hw/wb_regfile.sv ====
`timescale 1ns/10ps
`include "wb_cfg.svh"

module wb_regfile (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                we0,
    input  logic [`WB_RAW-1:0]  waddr0,
    input  logic [`WB_XLEN-1:0] wdata0,
    input  logic                we1,
    input  logic [`WB_RAW-1:0]  waddr1,
    input  logic [`WB_XLEN-1:0] wdata1,
    input  logic                we2,
    input  logic [`WB_RAW-1:0]  waddr2,
    input  logic [`WB_XLEN-1:0] wdata2,
    input  logic [`WB_RAW-1:0]  rd_addr_a,
    input  logic [`WB_RAW-1:0]  rd_addr_b,
    output logic [`WB_XLEN-1:0] rd_data_a,
    output logic [`WB_XLEN-1:0] rd_data_b
);

    logic [`WB_XLEN-1:0] regs [`WB_NREG];

    // later writes take effect last, so load beats lane 1 beats lane 0
    always_ff @(posedge clk) begin
        if (aresetn) begin
            if (we0 && waddr0 != '0) begin
                regs[waddr0] <= wdata0;
            end
            if (we1 && waddr1 != '0) begin
                regs[waddr1] <= wdata1;
            end
            if (we2 && waddr2 != '0) begin
                regs[waddr2] <= wdata2;
            end
        end
    end

    // r0 reads as zero, no bypass of same-cycle writes
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

// ==== hw/wb_subsystem.sv ====
`timescale 1ns/10ps
`include "wb_cfg.svh"

module wb_subsystem (
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 lane0_valid,
    input  logic [`WB_XLEN-1:0]  lane0_pc,
    input  logic [`WB_RAW-1:0]   lane0_rd,
    input  wb_pkg::uop_u         lane0_uop,
    input  logic [`WB_XLEN-1:0]  lane0_result,
    input  logic                 lane1_valid,
    input  logic [`WB_XLEN-1:0]  lane1_pc,
    input  logic [`WB_RAW-1:0]   lane1_rd,
    input  wb_pkg::uop_u         lane1_uop,
    input  logic [`WB_XLEN-1:0]  lane1_result,
    input  logic                 div_start,
    input  logic [`WB_XLEN-1:0]  div_dividend,
    input  logic [`WB_XLEN-1:0]  div_divisor,
    input  logic                 load_issue,
    input  logic [`WB_RAW-1:0]   load_rd,
    input  logic [`WB_XLEN-1:0]  load_data,
    input  logic                 load_ready,
    input  logic                 csr_rd_valid,
    input  logic [`WB_XLEN-1:0]  csr_rdata,
    input  logic                 exc_valid,
    input  logic [5:0]           exc_code,
    input  logic [`WB_XLEN-1:0]  exc_badv,
    input  logic [`WB_XLEN-1:0]  exc_era,
    input  logic                 intr,
    input  logic [`WB_XLEN-1:0]  eentry,
    input  logic [`WB_XLEN-1:0]  tlbrentry,
    input  logic [`WB_XLEN-1:0]  csr_era,
    input  logic [`WB_RAW-1:0]   rd_addr_a,
    input  logic [`WB_RAW-1:0]   rd_addr_b,
    output logic [`WB_XLEN-1:0]  rd_data_a,
    output logic [`WB_XLEN-1:0]  rd_data_b,
    output logic                 allowin,
    output logic                 redirect_valid,
    output logic [`WB_XLEN-1:0]  redirect_pc,
    output logic                 flush,
    output logic                 badv_we,
    output logic [`WB_XLEN-1:0]  badv,
    output logic                 era_we,
    output logic [`WB_XLEN-1:0]  era,
    output logic                 vppn_we,
    output logic [`WB_XLEN-14:0] vppn,
    output logic [5:0]           ecode_out
);

    logic                div_busy;
    logic                div_ready;
    logic [`WB_XLEN-1:0] quotient;
    logic [`WB_XLEN-1:0] remainder;
    logic                we0;
    logic [`WB_RAW-1:0]  waddr0;
    logic [`WB_XLEN-1:0] wdata0;
    logic                we1;
    logic [`WB_RAW-1:0]  waddr1;
    logic [`WB_XLEN-1:0] wdata1;
    logic                we2;
    logic [`WB_RAW-1:0]  waddr2;
    logic [`WB_XLEN-1:0] wdata2;
    logic [`WB_XLEN-1:0] commit_era;

    // interrupt returns to the oldest instruction in writeback
    assign commit_era = exc_valid ? exc_era : (lane0_valid ? lane0_pc : lane1_pc);

    int_divider u_div (
        .clk(clk), .aresetn(aresetn), .start(div_start),
        .dividend(div_dividend), .divisor(div_divisor),
        .busy(div_busy), .ready(div_ready),
        .quotient(quotient), .remainder(remainder)
    );

    wb_select u_sel (
        .clk(clk), .aresetn(aresetn), .flush(flush),
        .lane0_valid(lane0_valid), .lane0_rd(lane0_rd),
        .lane0_uop(lane0_uop), .lane0_result(lane0_result),
        .lane1_valid(lane1_valid), .lane1_rd(lane1_rd),
        .lane1_uop(lane1_uop), .lane1_result(lane1_result),
        .csr_rd_valid(csr_rd_valid), .csr_rdata(csr_rdata),
        .div_busy(div_busy), .div_ready(div_ready),
        .quotient(quotient), .remainder(remainder),
        .load_issue(load_issue), .load_rd(load_rd),
        .load_data(load_data), .load_ready(load_ready),
        .we0(we0), .waddr0(waddr0), .wdata0(wdata0),
        .we1(we1), .waddr1(waddr1), .wdata1(wdata1),
        .we2(we2), .waddr2(waddr2), .wdata2(wdata2),
        .allowin(allowin)
    );

    exc_commit u_exc (
        .clk(clk), .aresetn(aresetn),
        .exc_valid(exc_valid), .exc_code(exc_code),
        .exc_badv(exc_badv), .exc_era(commit_era), .intr(intr),
        .lane0_valid(lane0_valid), .lane0_uop(lane0_uop),
        .eentry(eentry), .tlbrentry(tlbrentry), .csr_era(csr_era),
        .flush(flush), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .ecode_out(ecode_out), .badv_we(badv_we), .badv(badv),
        .era_we(era_we), .era(era), .vppn_we(vppn_we), .vppn(vppn)
    );

    wb_regfile u_rf (
        .clk(clk), .aresetn(aresetn),
        .we0(we0), .waddr0(waddr0), .wdata0(wdata0),
        .we1(we1), .waddr1(waddr1), .wdata1(wdata1),
        .we2(we2), .waddr2(waddr2), .wdata2(wdata2),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
    );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic aresetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released just after an edge, like every other input
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 aresetn = 1'b1;
    end

endmodule

// ==== bench/tb_wb_subsystem.sv ====
`timescale 1ns/10ps
`include "wb_cfg.svh"

module tb_wb_subsystem;

    localparam int CLK_NS = 40;
    localparam int N_ALU  = 40;
    localparam int N_DIV  = 12;
    localparam int N_LOAD = 6;
    localparam int N_OPS  = 32 + N_ALU + N_DIV + N_LOAD + 30;

    // class field in the upper five bits: alu, link, div, mem, ertn
    localparam logic [7:0] OP_ALU   = 8'b10000_000;
    localparam logic [7:0] OP_LINK  = 8'b01000_000;
    localparam logic [7:0] OP_DIV   = 8'b00100_000;
    localparam logic [7:0] OP_LOAD  = 8'b00010_000;
    localparam logic [7:0] OP_STORE = 8'b00010_100;
    localparam logic [7:0] OP_ERTN  = 8'b00001_000;

    localparam logic [1:0] SRC_EXEC = 2'd0;
    localparam logic [1:0] SRC_CSR  = 2'd1;
    localparam logic [1:0] SRC_DIV  = 2'd2;

    logic                 clk;
    logic                 aresetn;
    logic                 lane0_valid, lane1_valid;
    logic [`WB_XLEN-1:0]  lane0_pc, lane1_pc, lane0_result, lane1_result;
    logic [`WB_RAW-1:0]   lane0_rd, lane1_rd, load_rd, rd_addr_a, rd_addr_b;
    wb_pkg::uop_u         lane0_uop, lane1_uop;
    logic                 div_start, load_issue, load_ready, csr_rd_valid;
    logic [`WB_XLEN-1:0]  div_dividend, div_divisor, load_data, csr_rdata;
    logic                 exc_valid, intr;
    logic [5:0]           exc_code;
    logic [`WB_XLEN-1:0]  exc_badv, exc_era, eentry, tlbrentry, csr_era;
    logic [`WB_XLEN-1:0]  rd_data_a, rd_data_b, redirect_pc, badv, era;
    logic                 allowin, redirect_valid, flush, badv_we, era_we, vppn_we;
    logic [`WB_XLEN-14:0] vppn;
    logic [5:0]           ecode_out;

    integer              seed = 32'h374c_d272;
    int                  err_count = 0;
    logic                cmp_en = 1'b0;
    string               test_name = "";
    logic [`WB_XLEN-1:0] shadow [`WB_NREG];

    tb_clock #(.PERIOD(CLK_NS), .RESET_CYCLES(5)) u_clock (.clk(clk), .aresetn(aresetn));

    wb_subsystem UUT (.*);

    task automatic check(input string name, input logic [`WB_XLEN-1:0] exp,
                         input logic [`WB_XLEN-1:0] act);
        if (act !== exp) begin
            err_count++;
            $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
            $display("Verification failed");
            $fatal;
        end
    endtask

    // expected writeback value for an execute, CSR or divide source
    function automatic logic [`WB_XLEN-1:0] ref_result(input logic [1:0] src,
            input logic [7:0] op, input logic [`WB_XLEN-1:0] a, input logic [`WB_XLEN-1:0] b);
        case (src)
            SRC_CSR: return a;
            SRC_DIV: begin
                if (b == '0) return op[0] ? a : '1;
                return op[0] ? a % b : a / b;
            end
            default: return ((op & OP_LINK) != 0) ? a + 32'd4 : a;
        endcase
    endfunction

    // {badv_we, vppn_we} for one exception code
    function automatic logic [1:0] exc_we_ref(input wb_pkg::ecode_e code);
        case (code)
            wb_pkg::PIL, wb_pkg::PIS, wb_pkg::PIF, wb_pkg::PME, wb_pkg::PPI,
            wb_pkg::TLBR: return 2'b11;
            wb_pkg::ADEF, wb_pkg::ALE: return 2'b10;
            default: return 2'b00;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_strobes();
        lane0_valid  = 1'b0;
        lane1_valid  = 1'b0;
        lane0_uop    = '0;
        lane1_uop    = '0;
        div_start    = 1'b0;
        load_issue   = 1'b0;
        load_ready   = 1'b0;
        csr_rd_valid = 1'b0;
        exc_valid    = 1'b0;
    endtask

    task automatic compare_all(input string name);
        test_name = name;
        for (int i = 0; i < `WB_NREG; i++) begin
            next_cycle();
            cmp_en    = 1'b1;
            rd_addr_a = `WB_RAW'(i);
            rd_addr_b = `WB_RAW'(`WB_NREG - 1 - i);
        end
        next_cycle();
        cmp_en = 1'b0;
    endtask

    task automatic divide(input logic [`WB_XLEN-1:0] a, input logic [`WB_XLEN-1:0] b,
                          input logic rem, input logic [`WB_RAW-1:0] rd,
                          input logic csr, input logic [`WB_XLEN-1:0] cdata);
        logic [7:0] op;
        op = OP_DIV | {7'b0, rem};
        next_cycle();
        div_start    = 1'b1;
        div_dividend = a;
        div_divisor  = b;
        lane0_valid  = 1'b1;
        lane0_rd     = rd;
        lane0_uop    = op;
        csr_rd_valid = csr;
        csr_rdata    = cdata;
        next_cycle();
        div_start = 1'b0;
        @(negedge clk);
        check("divider busy blocks allowin", 0, allowin);
        // allowin rises in the ready cycle, the watchdog covers a hang
        while (!allowin) @(negedge clk);
        next_cycle();
        clear_strobes();
        if (rd != '0) begin
            shadow[rd] = csr ? ref_result(SRC_CSR, op, cdata, '0) : ref_result(SRC_DIV, op, a, b);
        end
    endtask

    task automatic load_op(input logic [`WB_RAW-1:0] rd, input logic [`WB_XLEN-1:0] data,
                           input int wait_cycles);
        next_cycle();
        load_issue = 1'b1;
        load_rd    = rd;
        lane0_uop  = OP_LOAD;
        next_cycle();
        clear_strobes();
        repeat (wait_cycles) begin
            @(negedge clk);
            check("load outstanding blocks allowin", 0, allowin);
            next_cycle();
        end
        load_ready = 1'b1;
        load_data  = data;
        next_cycle();
        clear_strobes();
        if (rd != '0) shadow[rd] = data;
    endtask

    task automatic store_op(input logic [`WB_RAW-1:0] rd, input logic [`WB_XLEN-1:0] data);
        next_cycle();
        load_issue = 1'b1;
        load_rd    = rd;
        lane0_uop  = OP_STORE;
        next_cycle();
        clear_strobes();
        @(negedge clk);
        check("store leaves allowin high", 1, allowin);
        next_cycle();
        load_ready = 1'b1;
        load_data  = data;
        next_cycle();
        clear_strobes();
    endtask

    task automatic take_exception(input wb_pkg::ecode_e code);
        logic [`WB_XLEN-1:0] bv;
        logic [`WB_XLEN-1:0] ev;
        logic [1:0]          we;
        string               tag;
        bv  = $random(seed);
        ev  = $random(seed);
        we  = exc_we_ref(code);
        tag = $sformatf("exception %s", code.name());
        next_cycle();
        exc_valid = 1'b1;
        exc_code  = code;
        exc_badv  = bv;
        exc_era   = ev;
        next_cycle();
        clear_strobes();
        // meets the flush, must not land
        lane0_valid  = 1'b1;
        lane0_uop    = OP_ALU;
        lane0_rd     = `WB_RAW'($random(seed)) | `WB_RAW'(1);
        lane0_result = $random(seed);
        @(negedge clk);
        check({tag, " flush"}, 1, flush);
        check({tag, " redirect_valid"}, 1, redirect_valid);
        check({tag, " redirect_pc"}, (code == wb_pkg::TLBR) ? tlbrentry : eentry, redirect_pc);
        check({tag, " badv_we"}, we[1], badv_we);
        check({tag, " vppn_we"}, we[0], vppn_we);
        check({tag, " era_we"}, 1, era_we);
        check({tag, " ecode"}, code, ecode_out);
        check({tag, " badv"}, bv, badv);
        check({tag, " era"}, ev, era);
        check({tag, " vppn"}, bv[`WB_XLEN-1:13], vppn);
        next_cycle();
        clear_strobes();
        @(negedge clk);
        check({tag, " flush one cycle"}, 0, flush);
    endtask

    always @(negedge clk) begin
        if (cmp_en) begin
            check(test_name, shadow[rd_addr_a], rd_data_a);
            check(test_name, shadow[rd_addr_b], rd_data_b);
        end
    end

    initial begin
        #(N_OPS * (`WB_DIV_STEPS + 4) * CLK_NS);
        $display("timeout, the run did not finish within %0d cycles",
                 N_OPS * (`WB_DIV_STEPS + 4));
        $display("Verification failed");
        $fatal;
    end

    initial begin
        logic [`WB_RAW-1:0]  r0;
        logic [`WB_RAW-1:0]  r1;
        logic [`WB_XLEN-1:0] a;
        logic [`WB_XLEN-1:0] b;
        logic [7:0]          op0;
        logic [7:0]          op1;
        logic                v0;
        logic                v1;
        int                  sh;
        wb_pkg::ecode_e      codes [12];

        clear_strobes();
        {lane0_pc, lane1_pc, lane0_result, lane1_result} = '0;
        {lane0_rd, lane1_rd, load_rd, rd_addr_a, rd_addr_b} = '0;
        {div_dividend, div_divisor, load_data, csr_rdata} = '0;
        {exc_code, exc_badv, exc_era} = '0;
        intr      = 1'b0;
        eentry    = $random(seed);
        tlbrentry = $random(seed);
        csr_era   = $random(seed);
        foreach (shadow[i]) shadow[i] = '0;
        codes = '{wb_pkg::INT, wb_pkg::PIL, wb_pkg::PIS, wb_pkg::PIF, wb_pkg::PME, wb_pkg::PPI,
                  wb_pkg::ADEF, wb_pkg::ALE, wb_pkg::SYS, wb_pkg::BRK, wb_pkg::INE, wb_pkg::TLBR};

        wait (aresetn === 1'b1);
        @(negedge clk);
        check("reset flush", 0, flush);
        check("reset redirect_valid", 0, redirect_valid);
        check("reset badv_we", 0, badv_we);
        check("reset era_we", 0, era_we);
        check("reset vppn_we", 0, vppn_we);
        check("reset allowin", 1, allowin);

        // every register gets a known value, r0 included
        for (int i = 0; i < `WB_NREG; i++) begin
            next_cycle();
            a            = $random(seed);
            lane0_valid  = 1'b1;
            lane0_uop    = OP_ALU;
            lane0_rd     = `WB_RAW'(i);
            lane0_result = a;
            if (i != 0) shadow[i] = ref_result(SRC_EXEC, OP_ALU, a, '0);
            next_cycle();
            clear_strobes();
        end
        compare_all("initial writes");

        for (int n = 0; n < N_ALU; n++) begin
            r0  = `WB_RAW'($random(seed));
            r1  = `WB_RAW'($random(seed));
            if (r1 == r0 && r0 != '0) r1 = r0 + 1'b1;
            op0 = ($random(seed) & 1) ? OP_LINK : OP_ALU;
            op1 = ($random(seed) & 1) ? OP_LINK : OP_ALU;
            v0  = 1'($random(seed));
            v1  = 1'($random(seed));
            a   = $random(seed);
            b   = $random(seed);
            next_cycle();
            lane0_valid  = v0;
            lane0_rd     = r0;
            lane0_uop    = op0;
            lane0_result = a;
            lane1_valid  = v1;
            lane1_rd     = r1;
            lane1_uop    = op1;
            lane1_result = b;
            if (v0 && r0 != '0) shadow[r0] = ref_result(SRC_EXEC, op0, a, '0);
            if (v1 && r1 != '0) shadow[r1] = ref_result(SRC_EXEC, op1, b, '0);
            next_cycle();
            clear_strobes();
        end
        compare_all("alu and link writes");

        // first two divides by zero, then divisors of mixed size
        for (int n = 0; n < N_DIV; n++) begin
            a  = $random(seed);
            b  = $random(seed);
            sh = $random(seed) & 31;
            b  = (n < 2) ? '0 : b >> sh;
            r0 = `WB_RAW'($random(seed)) | `WB_RAW'(1);
            divide(a, b, 1'(n), r0, 1'b0, '0);
        end
        compare_all("divide");

        next_cycle();
        csr_rd_valid = 1'b1;
        csr_rdata    = $random(seed);
        lane0_rd     = 5'd7;
        shadow[7]    = ref_result(SRC_CSR, OP_ALU, csr_rdata, '0);
        next_cycle();
        clear_strobes();
        divide($random(seed), 32'd3, 1'b0, 5'd9, 1'b1, $random(seed));
        compare_all("csr read");

        for (int n = 0; n < N_LOAD; n++) begin
            sh = 1 + ($unsigned($random(seed)) % 6);
            load_op(`WB_RAW'($random(seed)), $random(seed), sh);
        end
        store_op(5'd3, $random(seed));
        store_op(5'd12, $random(seed));
        compare_all("load and store");

        foreach (codes[k]) take_exception(codes[k]);
        next_cycle();
        lane0_valid = 1'b1;
        lane0_uop   = OP_ERTN;
        next_cycle();
        clear_strobes();
        @(negedge clk);
        check("ertn redirect_valid", 1, redirect_valid);
        check("ertn flush", 1, flush);
        check("ertn redirect_pc", csr_era, redirect_pc);
        check("ertn era_we", 0, era_we);
        compare_all("flush suppression");

        if (err_count != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
hw/wb_pkg.sv
hw/int_divider.sv
hw/wb_select.sv
hw/exc_commit.sv
hw/wb_regfile.sv
hw/wb_subsystem.sv
bench/tb_clock.sv
bench/tb_wb_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_wb_subsystem \
    -o sim_wb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_wb > sim.log 2>&1; cat sim.log
grep -q "Verification failed" sim.log && exit 1 || grep -q "Verification passed" sim.log || exit 1
